// ==== logic/vseq_pkg.sv ====
package vseq_pkg;

  ////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////

  // Instruction IDs in flight at once
  localparam int unsigned NrVInsn = 8;

  // Architectural vector registers
  localparam int unsigned NrVRegs = 32;

  // v0 holds the mask when vm is low
  localparam int unsigned MaskReg = 0;

  // Functional units behind the sequencer
  localparam int unsigned NrUnits = 4;

  // Credit counters must reach the deepest queue
  localparam int unsigned CntWidth = 3;

  ////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////

  // The dispatcher names the unit directly
  typedef enum logic [1:0] {
    UnitAlu   = 2'd0,
    UnitMul   = 2'd1,
    UnitLoad  = 2'd2,
    UnitStore = 2'd3
  } unit_e;

  // Instruction ID
  typedef logic [$clog2(NrVInsn)-1:0] vid_t;

  // Vector register index
  typedef logic [$clog2(NrVRegs)-1:0] vreg_t;

  // One bit per instruction ID
  typedef logic [NrVInsn-1:0] vinsn_vec_t;

  // In-flight count of one unit
  typedef logic [CntWidth-1:0] cnt_t;

  // Queue depth of each unit indexed by unit_e
  localparam cnt_t UnitDepth [NrUnits] = '{
    cnt_t'(4),
    cnt_t'(2),
    cnt_t'(2),
    cnt_t'(2)
  };

endpackage

// ==== logic/vinsn_tracker.sv ====
`timescale 1ns/1ps

module vinsn_tracker (
  input  logic                                             clk_i,
  input  logic                                             rst_ni,
  input  logic                                             accept_i,
  input  vseq_pkg::unit_e                                  req_unit_i,
  input  vseq_pkg::vinsn_vec_t [vseq_pkg::NrUnits-1:0]     done_i,
  output vseq_pkg::vid_t                                   next_id_o,
  output logic                                             id_free_o,
  output vseq_pkg::vinsn_vec_t                             running_o,
  output vseq_pkg::vinsn_vec_t                             running_next_o,
  output logic                                             idle_o
);

  ////////////////////////////////////////////////////////////
  // Running matrix
  ////////////////////////////////////////////////////////////

  // One row per unit with a bit for each ID running there
  vseq_pkg::vinsn_vec_t [vseq_pkg::NrUnits-1:0] unit_running_d, unit_running_q;

  always_comb begin
    // Completions clear their bits
    for (int u = 0; u < vseq_pkg::NrUnits; u++) begin
      unit_running_d[u] = unit_running_q[u] & ~done_i[u];
    end
    // New instruction starts on its unit
    if (accept_i) begin
      unit_running_d[req_unit_i][next_id_o] = 1'b1;
    end
    // Union over all units
    running_next_o = '0;
    for (int u = 0; u < vseq_pkg::NrUnits; u++) begin
      running_next_o = running_next_o | unit_running_d[u];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      unit_running_q <= '0;
      running_o      <= '0;
    end else begin
      unit_running_q <= unit_running_d;
      running_o      <= running_next_o;
    end
  end

  ////////////////////////////////////////////////////////////
  // Next free ID
  ////////////////////////////////////////////////////////////

  // Lowest zero of the registered running set
  always_comb begin
    next_id_o = '0;
    id_free_o = 1'b0;
    // Walk downwards so the lowest free ID wins
    for (int i = vseq_pkg::NrVInsn - 1; i >= 0; i--) begin
      if (!running_o[i]) begin
        next_id_o = vseq_pkg::vid_t'(i);
        id_free_o = 1'b1;
      end
    end
  end

  // Nothing in flight anywhere
  assign idle_o = ~|running_o;

endmodule

// ==== logic/vreg_scoreboard.sv ====
`timescale 1ns/1ps

module vreg_scoreboard (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  logic                                          accept_i,
  input  vseq_pkg::vid_t                                new_id_i,
  input  vseq_pkg::vreg_t                               req_vd_i,
  input  vseq_pkg::vreg_t                               req_vs1_i,
  input  vseq_pkg::vreg_t                               req_vs2_i,
  input  logic                                          req_use_vd_i,
  input  logic                                          req_use_vs1_i,
  input  logic                                          req_use_vs2_i,
  input  logic                                          req_vm_i,
  input  vseq_pkg::vinsn_vec_t                          running_i,
  input  vseq_pkg::vinsn_vec_t                          running_next_i,
  output vseq_pkg::vinsn_vec_t                          hazard_o,
  output vseq_pkg::vinsn_vec_t [vseq_pkg::NrVInsn-1:0]  hazard_table_o
);

  ////////////////////////////////////////////////////////////
  // Access lists
  ////////////////////////////////////////////////////////////

  // Last writer and last reader of every register
  vseq_pkg::vid_t wr_id_d [vseq_pkg::NrVRegs];
  vseq_pkg::vid_t wr_id_q [vseq_pkg::NrVRegs];
  vseq_pkg::vid_t rd_id_d [vseq_pkg::NrVRegs];
  vseq_pkg::vid_t rd_id_q [vseq_pkg::NrVRegs];
  logic [vseq_pkg::NrVRegs-1:0] wr_vld_d, wr_vld_q;
  logic [vseq_pkg::NrVRegs-1:0] rd_vld_d, rd_vld_q;

  // Entries whose owner still runs
  logic [vseq_pkg::NrVRegs-1:0] wr_live, rd_live;

  vseq_pkg::vinsn_vec_t [vseq_pkg::NrVInsn-1:0] table_d;

  always_comb begin
    for (int v = 0; v < vseq_pkg::NrVRegs; v++) begin
      wr_live[v] = wr_vld_q[v] & running_i[wr_id_q[v]];
      rd_live[v] = rd_vld_q[v] & running_i[rd_id_q[v]];
    end
  end

  ////////////////////////////////////////////////////////////
  // Hazard lookup
  ////////////////////////////////////////////////////////////

  always_comb begin
    hazard_o = '0;
    // RAW on the sources
    if (req_use_vs1_i && wr_live[req_vs1_i]) begin
      hazard_o[wr_id_q[req_vs1_i]] = 1'b1;
    end
    if (req_use_vs2_i && wr_live[req_vs2_i]) begin
      hazard_o[wr_id_q[req_vs2_i]] = 1'b1;
    end
    // RAW on the mask
    if (!req_vm_i && wr_live[vseq_pkg::MaskReg]) begin
      hazard_o[wr_id_q[vseq_pkg::MaskReg]] = 1'b1;
    end
    if (req_use_vd_i) begin
      // WAR
      if (rd_live[req_vd_i]) begin
        hazard_o[rd_id_q[req_vd_i]] = 1'b1;
      end
      // WAW
      if (wr_live[req_vd_i]) begin
        hazard_o[wr_id_q[req_vd_i]] = 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // List and table update
  ////////////////////////////////////////////////////////////

  always_comb begin
    // Drop finished owners
    wr_id_d  = wr_id_q;
    rd_id_d  = rd_id_q;
    wr_vld_d = wr_live;
    rd_vld_d = rd_live;
    table_d  = hazard_table_o;
    if (accept_i) begin
      // Destination now belongs to the new ID
      if (req_use_vd_i) begin
        wr_id_d[req_vd_i]  = new_id_i;
        wr_vld_d[req_vd_i] = 1'b1;
      end
      // Readers after the lookup above
      if (req_use_vs1_i) begin
        rd_id_d[req_vs1_i]  = new_id_i;
        rd_vld_d[req_vs1_i] = 1'b1;
      end
      if (req_use_vs2_i) begin
        rd_id_d[req_vs2_i]  = new_id_i;
        rd_vld_d[req_vs2_i] = 1'b1;
      end
      if (!req_vm_i) begin
        rd_id_d[vseq_pkg::MaskReg]  = new_id_i;
        rd_vld_d[vseq_pkg::MaskReg] = 1'b1;
      end
      table_d[new_id_i] = hazard_o;
    end
    // Rows keep only instructions still in flight
    for (int i = 0; i < vseq_pkg::NrVInsn; i++) begin
      table_d[i] = table_d[i] & running_next_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_vld_q       <= '0;
      rd_vld_q       <= '0;
      hazard_table_o <= '0;
    end else begin
      wr_vld_q       <= wr_vld_d;
      rd_vld_q       <= rd_vld_d;
      hazard_table_o <= table_d;
    end
  end

  // Owner IDs of the list entries
  always_ff @(posedge clk_i) begin
    wr_id_q <= wr_id_d;
    rd_id_q <= rd_id_d;
  end

endmodule

// ==== logic/unit_credits.sv ====
`timescale 1ns/1ps

module unit_credits (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  logic                                          accept_i,
  input  vseq_pkg::unit_e                               req_unit_i,
  input  vseq_pkg::vinsn_vec_t [vseq_pkg::NrUnits-1:0]  done_i,
  output logic [vseq_pkg::NrUnits-1:0]                  unit_ready_o
);

  ////////////////////////////////////////////////////////////
  // One credit counter per unit
  ////////////////////////////////////////////////////////////

  for (genvar u = 0; u < vseq_pkg::NrUnits; u++) begin : gen_cnt
    vseq_pkg::cnt_t cnt_q;
    logic           cnt_up;
    logic           cnt_down;

    // New instruction for this unit
    assign cnt_up = accept_i && (req_unit_i == vseq_pkg::unit_e'(u));

    // At most one completion per unit and cycle
    assign cnt_down = |done_i[u];

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        cnt_q <= '0;
      end else if (cnt_up && !cnt_down) begin
        cnt_q <= cnt_q + vseq_pkg::cnt_t'(1);
      end else if (cnt_down && !cnt_up) begin
        cnt_q <= cnt_q - vseq_pkg::cnt_t'(1);
      end
      // Up and down together leave the count alone
    end

    // Room left in the unit queue
    assign unit_ready_o[u] = cnt_q < vseq_pkg::UnitDepth[u];
  end

endmodule

// ==== logic/issue_ctrl.sv ====
`timescale 1ns/1ps

module issue_ctrl (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // Dispatcher side
  input  logic                          req_valid_i,
  input  vseq_pkg::unit_e               req_unit_i,
  input  vseq_pkg::vreg_t               req_vd_i,
  input  vseq_pkg::vreg_t               req_vs1_i,
  input  vseq_pkg::vreg_t               req_vs2_i,
  input  logic                          req_vm_i,
  output logic                          req_ready_o,
  // From the other blocks
  input  logic                          id_free_i,
  input  logic [vseq_pkg::NrUnits-1:0]  unit_ready_i,
  input  vseq_pkg::vid_t                next_id_i,
  input  vseq_pkg::vinsn_vec_t          hazard_i,
  output logic                          accept_o,
  // Issue strobe
  output logic                          issue_valid_o,
  output vseq_pkg::vid_t                issue_id_o,
  output vseq_pkg::unit_e               issue_unit_o,
  output vseq_pkg::vreg_t               issue_vd_o,
  output vseq_pkg::vreg_t               issue_vs1_o,
  output vseq_pkg::vreg_t               issue_vs2_o,
  output logic                          issue_vm_o,
  output vseq_pkg::vinsn_vec_t          issue_hazard_o
);

  ////////////////////////////////////////////////////////////
  // Acceptance
  ////////////////////////////////////////////////////////////

  // Hazards never block since the units chain on them
  assign req_ready_o = id_free_i & unit_ready_i[req_unit_i];
  assign accept_o    = req_valid_i & req_ready_o;

  ////////////////////////////////////////////////////////////
  // Issue register
  ////////////////////////////////////////////////////////////

  // One-cycle strobe
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issue_valid_o <= 1'b0;
    end else begin
      issue_valid_o <= accept_o;
    end
  end

  // Fields load with the accepted request
  always_ff @(posedge clk_i) begin
    if (accept_o) begin
      issue_id_o     <= next_id_i;
      issue_unit_o   <= req_unit_i;
      issue_vd_o     <= req_vd_i;
      issue_vs1_o    <= req_vs1_i;
      issue_vs2_o    <= req_vs2_i;
      issue_vm_o     <= req_vm_i;
      issue_hazard_o <= hazard_i;
    end
  end

endmodule

// ==== logic/vector_sequencer.sv ====
`timescale 1ns/1ps

module vector_sequencer (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  // Dispatcher handshake
  input  logic                                          req_valid_i,
  input  vseq_pkg::unit_e                               req_unit_i,
  input  vseq_pkg::vreg_t                               req_vd_i,
  input  vseq_pkg::vreg_t                               req_vs1_i,
  input  vseq_pkg::vreg_t                               req_vs2_i,
  input  logic                                          req_use_vd_i,
  input  logic                                          req_use_vs1_i,
  input  logic                                          req_use_vs2_i,
  input  logic                                          req_vm_i,
  output logic                                          req_ready_o,
  // Completions, one ID vector per unit
  input  vseq_pkg::vinsn_vec_t [vseq_pkg::NrUnits-1:0]  done_i,
  // Issue strobe
  output logic                                          issue_valid_o,
  output vseq_pkg::vid_t                                issue_id_o,
  output vseq_pkg::unit_e                               issue_unit_o,
  output vseq_pkg::vreg_t                               issue_vd_o,
  output vseq_pkg::vreg_t                               issue_vs1_o,
  output vseq_pkg::vreg_t                               issue_vs2_o,
  output logic                                          issue_vm_o,
  output vseq_pkg::vinsn_vec_t                          issue_hazard_o,
  // Status
  output vseq_pkg::vinsn_vec_t                          running_o,
  output vseq_pkg::vinsn_vec_t [vseq_pkg::NrVInsn-1:0]  hazard_table_o,
  output logic                                          idle_o
);

  logic                         accept;
  vseq_pkg::vid_t               next_id;
  logic                         id_free;
  vseq_pkg::vinsn_vec_t         running_next;
  logic [vseq_pkg::NrUnits-1:0] unit_ready;
  vseq_pkg::vinsn_vec_t         hazard;

  // ID allocation and where each instruction runs
  vinsn_tracker u_tracker (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .accept_i       (accept),
    .req_unit_i     (req_unit_i),
    .done_i         (done_i),
    .next_id_o      (next_id),
    .id_free_o      (id_free),
    .running_o      (running_o),
    .running_next_o (running_next),
    .idle_o         (idle_o)
  );

  // Register dependencies and hazard table
  vreg_scoreboard u_scoreboard (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .accept_i       (accept),
    .new_id_i       (next_id),
    .req_vd_i       (req_vd_i),
    .req_vs1_i      (req_vs1_i),
    .req_vs2_i      (req_vs2_i),
    .req_use_vd_i   (req_use_vd_i),
    .req_use_vs1_i  (req_use_vs1_i),
    .req_use_vs2_i  (req_use_vs2_i),
    .req_vm_i       (req_vm_i),
    .running_i      (running_o),
    .running_next_i (running_next),
    .hazard_o       (hazard),
    .hazard_table_o (hazard_table_o)
  );

  // Per-unit queue credits
  unit_credits u_credits (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .accept_i     (accept),
    .req_unit_i   (req_unit_i),
    .done_i       (done_i),
    .unit_ready_o (unit_ready)
  );

  // Handshake and issue strobe
  issue_ctrl u_issue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_valid_i    (req_valid_i),
    .req_unit_i     (req_unit_i),
    .req_vd_i       (req_vd_i),
    .req_vs1_i      (req_vs1_i),
    .req_vs2_i      (req_vs2_i),
    .req_vm_i       (req_vm_i),
    .req_ready_o    (req_ready_o),
    .id_free_i      (id_free),
    .unit_ready_i   (unit_ready),
    .next_id_i      (next_id),
    .hazard_i       (hazard),
    .accept_o       (accept),
    .issue_valid_o  (issue_valid_o),
    .issue_id_o     (issue_id_o),
    .issue_unit_o   (issue_unit_o),
    .issue_vd_o     (issue_vd_o),
    .issue_vs1_o    (issue_vs1_o),
    .issue_vs2_o    (issue_vs2_o),
    .issue_vm_o     (issue_vm_o),
    .issue_hazard_o (issue_hazard_o)
  );

endmodule

// ==== sim/tb_vector_sequencer.sv ====
`timescale 1ns/1ps

module tb_vector_sequencer;

  localparam int unsigned Seed      = 56196;
  localparam int          NumCycles = 2000;
  // Stimulus length plus half again for reset and slack
  localparam int          WatchdogCycles = NumCycles + NumCycles / 2;

  logic clk_i = 1'b0;
  logic rst_ni;

  // Dispatcher side
  logic                 req_valid, req_ready;
  vseq_pkg::unit_e      req_unit;
  vseq_pkg::vreg_t      req_vd, req_vs1, req_vs2;
  logic                 req_use_vd, req_use_vs1, req_use_vs2, req_vm;
  vseq_pkg::vinsn_vec_t [vseq_pkg::NrUnits-1:0] done;

  // Issue strobe and status
  logic                 issue_valid, issue_vm, idle;
  vseq_pkg::vid_t       issue_id;
  vseq_pkg::unit_e      issue_unit;
  vseq_pkg::vreg_t      issue_vd, issue_vs1, issue_vs2;
  vseq_pkg::vinsn_vec_t issue_hazard, running;
  vseq_pkg::vinsn_vec_t [vseq_pkg::NrVInsn-1:0] hazard_table;

  ////////////////////////////////////////////////////////////
  // Reference model state
  ////////////////////////////////////////////////////////////

  vseq_pkg::vinsn_vec_t m_run [4];
  int                   m_cnt [4];
  vseq_pkg::vinsn_vec_t m_table [8];
  vseq_pkg::vid_t       m_wr_id [32];
  vseq_pkg::vid_t       m_rd_id [32];
  logic                 m_wr_vld [32];
  logic                 m_rd_vld [32];

  // Request seen in the sampled cycle and checked on the strobe one cycle later
  logic                 cur_accept;
  vseq_pkg::vid_t       cur_id;
  vseq_pkg::unit_e      cur_unit;
  vseq_pkg::vreg_t      cur_vd, cur_vs1, cur_vs2;
  logic                 cur_use_vd, cur_use_vs1, cur_use_vs2, cur_vm;
  vseq_pkg::vinsn_vec_t cur_hazard;
  vseq_pkg::vinsn_vec_t [vseq_pkg::NrUnits-1:0] cur_done;

  vector_sequencer u_dut (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_valid_i    (req_valid),
    .req_unit_i     (req_unit),
    .req_vd_i       (req_vd),
    .req_vs1_i      (req_vs1),
    .req_vs2_i      (req_vs2),
    .req_use_vd_i   (req_use_vd),
    .req_use_vs1_i  (req_use_vs1),
    .req_use_vs2_i  (req_use_vs2),
    .req_vm_i       (req_vm),
    .req_ready_o    (req_ready),
    .done_i         (done),
    .issue_valid_o  (issue_valid),
    .issue_id_o     (issue_id),
    .issue_unit_o   (issue_unit),
    .issue_vd_o     (issue_vd),
    .issue_vs1_o    (issue_vs1),
    .issue_vs2_o    (issue_vs2),
    .issue_vm_o     (issue_vm),
    .issue_hazard_o (issue_hazard),
    .running_o      (running),
    .hazard_table_o (hazard_table),
    .idle_o         (idle)
  );

  always #5 clk_i = ~clk_i;

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // ALU queue holds 4 and the other units 2
  function automatic int unit_depth(input logic [1:0] unit);
    if (unit == 2'd0) begin
      return 4;
    end else begin
      return 2;
    end
  endfunction

  function automatic vseq_pkg::vinsn_vec_t model_running();
    vseq_pkg::vinsn_vec_t r;
    r = '0;
    for (int u = 0; u < 4; u++) begin
      r = r | m_run[u];
    end
    return r;
  endfunction

  function automatic logic model_ready();
    return (model_running() != 8'hff) && (m_cnt[req_unit] < unit_depth(req_unit));
  endfunction

  // Small register pool most of the time so dependencies show up often
  function automatic vseq_pkg::vreg_t rand_vreg();
    if (($urandom % 4) == 0) begin
      return vseq_pkg::vreg_t'($urandom);
    end else begin
      return vseq_pkg::vreg_t'($urandom % 6);
    end
  endfunction

  ////////////////////////////////////////////////////////////
  // Checker
  ////////////////////////////////////////////////////////////

  task automatic check_outputs();
    vseq_pkg::vinsn_vec_t run;
    run = model_running();
    check_eq("running_o", 32'(running), 32'(run));
    check_eq("idle_o", 32'(idle), 32'(run == '0));
    for (int i = 0; i < 8; i++) begin
      check_eq($sformatf("hazard_table_o[%0d]", i), 32'(hazard_table[i]), 32'(m_table[i]));
    end
    check_eq("req_ready_o", 32'(req_ready), 32'(model_ready()));
    check_eq("issue_valid_o", 32'(issue_valid), 32'(cur_accept));
    if (cur_accept) begin
      check_eq("issue_id_o", 32'(issue_id), 32'(cur_id));
      check_eq("issue_unit_o", 32'(issue_unit), 32'(cur_unit));
      check_eq("issue_vd_o", 32'(issue_vd), 32'(cur_vd));
      check_eq("issue_vs1_o", 32'(issue_vs1), 32'(cur_vs1));
      check_eq("issue_vs2_o", 32'(issue_vs2), 32'(cur_vs2));
      check_eq("issue_vm_o", 32'(issue_vm), 32'(cur_vm));
      check_eq("issue_hazard_o", 32'(issue_hazard), 32'(cur_hazard));
    end
  endtask

  // Lowest free ID and RAW/WAR/WAW vector against the lists as they stand
  task automatic sample_request();
    vseq_pkg::vinsn_vec_t run;
    run = model_running();
    cur_accept = req_valid && model_ready();
    cur_id = '0;
    for (int i = 7; i >= 0; i--) begin
      if (!run[i]) begin
        cur_id = vseq_pkg::vid_t'(i);
      end
    end
    cur_hazard = '0;
    if (req_use_vs1 && m_wr_vld[req_vs1] && run[m_wr_id[req_vs1]]) begin
      cur_hazard[m_wr_id[req_vs1]] = 1'b1;
    end
    if (req_use_vs2 && m_wr_vld[req_vs2] && run[m_wr_id[req_vs2]]) begin
      cur_hazard[m_wr_id[req_vs2]] = 1'b1;
    end
    // Masked instructions read v0
    if (!req_vm && m_wr_vld[0] && run[m_wr_id[0]]) begin
      cur_hazard[m_wr_id[0]] = 1'b1;
    end
    if (req_use_vd && m_rd_vld[req_vd] && run[m_rd_id[req_vd]]) begin
      cur_hazard[m_rd_id[req_vd]] = 1'b1;
    end
    if (req_use_vd && m_wr_vld[req_vd] && run[m_wr_id[req_vd]]) begin
      cur_hazard[m_wr_id[req_vd]] = 1'b1;
    end
    cur_unit    = req_unit;
    cur_vd      = req_vd;
    cur_vs1     = req_vs1;
    cur_vs2     = req_vs2;
    cur_use_vd  = req_use_vd;
    cur_use_vs1 = req_use_vs1;
    cur_use_vs2 = req_use_vs2;
    cur_vm      = req_vm;
    cur_done    = done;
  endtask

  task automatic update_model();
    vseq_pkg::vinsn_vec_t run_reg;
    vseq_pkg::vinsn_vec_t run_next;
    logic                 up;
    logic                 down;
    run_reg = model_running();
    // Entries of finished IDs drop out
    for (int v = 0; v < 32; v++) begin
      m_wr_vld[v] = m_wr_vld[v] && run_reg[m_wr_id[v]];
      m_rd_vld[v] = m_rd_vld[v] && run_reg[m_rd_id[v]];
    end
    for (int u = 0; u < 4; u++) begin
      m_run[u] = m_run[u] & ~cur_done[u];
    end
    if (cur_accept) begin
      m_run[cur_unit][cur_id] = 1'b1;
      if (cur_use_vd) begin
        m_wr_id[cur_vd]  = cur_id;
        m_wr_vld[cur_vd] = 1'b1;
      end
      if (cur_use_vs1) begin
        m_rd_id[cur_vs1]  = cur_id;
        m_rd_vld[cur_vs1] = 1'b1;
      end
      if (cur_use_vs2) begin
        m_rd_id[cur_vs2]  = cur_id;
        m_rd_vld[cur_vs2] = 1'b1;
      end
      if (!cur_vm) begin
        m_rd_id[0]  = cur_id;
        m_rd_vld[0] = 1'b1;
      end
      m_table[cur_id] = cur_hazard;
    end
    // Credits hold when up and down meet
    for (int u = 0; u < 4; u++) begin
      up   = cur_accept && (cur_unit == vseq_pkg::unit_e'(u));
      down = |cur_done[u];
      if (up && !down) begin
        m_cnt[u]++;
      end else if (down && !up) begin
        m_cnt[u]--;
      end
    end
    run_next = model_running();
    for (int i = 0; i < 8; i++) begin
      m_table[i] = m_table[i] & run_next;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  task automatic drive_inputs();
    vseq_pkg::vinsn_vec_t [vseq_pkg::NrUnits-1:0] pick;
    int   start;
    int   j;
    logic found;
    // Request stays put until it is taken
    if (!req_valid || cur_accept) begin
      req_valid   <= ($urandom % 4) != 0;
      req_unit    <= vseq_pkg::unit_e'($urandom % 4);
      req_vd      <= rand_vreg();
      req_vs1     <= rand_vreg();
      req_vs2     <= rand_vreg();
      req_use_vd  <= ($urandom % 4) != 0;
      req_use_vs1 <= ($urandom % 4) != 0;
      req_use_vs2 <= ($urandom % 2) != 0;
      req_vm      <= ($urandom % 2) != 0;
    end
    // At most one completion per unit and only for IDs running there
    pick = '0;
    for (int u = 0; u < 4; u++) begin
      start = $urandom % 8;
      found = 1'b0;
      if (($urandom % 3) == 0) begin
        for (int k = 0; k < 8; k++) begin
          j = (start + k) % 8;
          if (!found && m_run[u][j]) begin
            pick[u][j] = 1'b1;
            found = 1'b1;
          end
        end
      end
    end
    done <= pick;
  endtask

  initial begin
    void'($urandom(Seed));
    rst_ni      <= 1'b0;
    req_valid   <= 1'b0;
    req_unit    <= vseq_pkg::UnitAlu;
    req_vd      <= '0;
    req_vs1     <= '0;
    req_vs2     <= '0;
    req_use_vd  <= 1'b0;
    req_use_vs1 <= 1'b0;
    req_use_vs2 <= 1'b0;
    req_vm      <= 1'b1;
    done        <= '0;
    for (int i = 0; i < 32; i++) begin
      m_wr_vld[i] = 1'b0;
      m_rd_vld[i] = 1'b0;
      m_wr_id[i]  = '0;
      m_rd_id[i]  = '0;
    end
    for (int i = 0; i < 8; i++) begin
      m_table[i] = '0;
    end
    for (int u = 0; u < 4; u++) begin
      m_run[u] = '0;
      m_cnt[u] = 0;
    end
    cur_accept = 1'b0;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    // First pass checks the state right after reset
    for (int cyc = 0; cyc < NumCycles; cyc++) begin
      @(negedge clk_i);
      check_outputs();
      sample_request();
      @(posedge clk_i);
      update_model();
      drive_inputs();
    end
    $display("TEST PASSED");
    $finish;
  end

  // Watchdog
  initial begin
    repeat (WatchdogCycles) @(posedge clk_i);
    $display("Watchdog expired before the stimulus loop finished");
    $display("TEST FAILED");
    $fatal(1, "Timeout");
  end

endmodule

// ==== filelist.f ====
logic/vseq_pkg.sv
logic/vinsn_tracker.sv
logic/vreg_scoreboard.sv
logic/unit_credits.sv
logic/issue_ctrl.sv
logic/vector_sequencer.sv
sim/tb_vector_sequencer.sv

// ==== Makefile ====
# Verilator flow for the vector sequencer

.PHONY: all lint sim clean

all: sim

# Lint the RTL top level
lint:
	verilator --lint-only --timing -f filelist.f --top-module vector_sequencer

# Build and run the testbench, pass only when the log holds the pass line
sim:
	verilator --binary --timing -f filelist.f --top-module tb_vector_sequencer \
		-o Vtb_vector_sequencer
	./obj_dir/Vtb_vector_sequencer > sim.log 2>&1 || true
	cat sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
